/* hdl/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////

	// Column and row counters, wide enough for a full line
	parameter int COUNT_W = 10;

	// Dot colour code from the pixel source
	// Also the width of the palette index
	parameter int DOT_W = 8;

	// One colour component per output DAC
	parameter int COLOR_W = 4;

	////////////////////////////////////////////////////////////
	// Default raster geometry
	////////////////////////////////////////////////////////////

	// Horizontal, in pixel clocks
	// 288 + 32 + 32 + 32 = 384 clocks per line
	parameter int DEF_ACTIVE_COLS = 288;
	parameter int DEF_FRONT_H     = 32;
	parameter int DEF_SYNC_H      = 32;
	parameter int DEF_BACK_H      = 32;

	// Vertical, in whole lines
	// 224 + 48 + 8 + 8 = 288 lines per frame
	parameter int DEF_ACTIVE_ROWS = 224;
	parameter int DEF_FRONT_V     = 48;
	parameter int DEF_SYNC_V      = 8;
	parameter int DEF_BACK_V      = 8;

	// Phase order is the same on both axes
	// Active, front porch, sync, back porch

endpackage

/* hdl/video_timing.sv */
`timescale 1ns/1ns

module video_timing #(
	parameter int ACTIVE_COLS = video_pkg::DEF_ACTIVE_COLS,
	parameter int FRONT_H     = video_pkg::DEF_FRONT_H,
	parameter int SYNC_H      = video_pkg::DEF_SYNC_H,
	parameter int BACK_H      = video_pkg::DEF_BACK_H,
	parameter int ACTIVE_ROWS = video_pkg::DEF_ACTIVE_ROWS,
	parameter int FRONT_V     = video_pkg::DEF_FRONT_V,
	parameter int SYNC_V      = video_pkg::DEF_SYNC_V,
	parameter int BACK_V      = video_pkg::DEF_BACK_V
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	output logic [video_pkg::COUNT_W-1:0] o_col,
	output logic [video_pkg::COUNT_W-1:0] o_row,
	output logic                          o_active,
	output logic                          o_hsync_n,
	output logic                          o_vsync_n,
	output logic                          o_hblank,
	output logic                          o_vblank
);

	import video_pkg::*;

	typedef enum logic [1:0] {
		PH_ACTIVE,
		PH_FRONT,
		PH_SYNC,
		PH_BACK
	} h_phase_t;

	// Last column of each horizontal phase
	localparam logic [COUNT_W-1:0] H_ACT_LAST   = COUNT_W'(ACTIVE_COLS - 1);
	localparam logic [COUNT_W-1:0] H_FRONT_LAST = COUNT_W'(ACTIVE_COLS + FRONT_H - 1);
	localparam logic [COUNT_W-1:0] H_SYNC_LAST  = COUNT_W'(ACTIVE_COLS + FRONT_H + SYNC_H - 1);
	localparam logic [COUNT_W-1:0] H_LAST =
		COUNT_W'(ACTIVE_COLS + FRONT_H + SYNC_H + BACK_H - 1);

	// Vertical boundaries in rows
	localparam logic [COUNT_W-1:0] V_ACT_END    = COUNT_W'(ACTIVE_ROWS);
	localparam logic [COUNT_W-1:0] V_SYNC_START = COUNT_W'(ACTIVE_ROWS + FRONT_V);
	localparam logic [COUNT_W-1:0] V_SYNC_END   = COUNT_W'(ACTIVE_ROWS + FRONT_V + SYNC_V);
	localparam logic [COUNT_W-1:0] V_LAST =
		COUNT_W'(ACTIVE_ROWS + FRONT_V + SYNC_V + BACK_V - 1);

	h_phase_t           phase;
	h_phase_t           phase_nxt;
	logic [COUNT_W-1:0] col;
	logic [COUNT_W-1:0] col_nxt;
	logic [COUNT_W-1:0] row;
	logic [COUNT_W-1:0] row_nxt;
	logic               line_end;
	logic               hblank_nxt;
	logic               hsync_n_nxt;
	logic               vblank_nxt;
	logic               vsync_n_nxt;

	////////////////////////////////////////////////////////////
	// Horizontal phase FSM
	////////////////////////////////////////////////////////////

	// Phase moves on at the last column of each phase
	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_ACTIVE: if (col == H_ACT_LAST) begin
				phase_nxt = PH_FRONT;
			end
			PH_FRONT: if (col == H_FRONT_LAST) begin
				phase_nxt = PH_SYNC;
			end
			PH_SYNC: if (col == H_SYNC_LAST) begin
				phase_nxt = PH_BACK;
			end
			PH_BACK: if (col == H_LAST) begin
				phase_nxt = PH_ACTIVE;
			end
			default: phase_nxt = PH_ACTIVE;
		endcase
	end

	// Line wrap at the end of back porch
	assign line_end = (phase == PH_BACK) && (col == H_LAST);
	assign col_nxt  = line_end ? '0 : col + 1'b1;

	// Rows step once per line, wrap at frame end
	always_comb begin
		row_nxt = row;
		if (line_end) begin
			row_nxt = (row == V_LAST) ? '0 : row + 1'b1;
		end
	end

	// Level decode from the next position
	assign hblank_nxt  = (phase_nxt != PH_ACTIVE);
	assign hsync_n_nxt = (phase_nxt != PH_SYNC);
	assign vblank_nxt  = (row_nxt >= V_ACT_END);
	assign vsync_n_nxt = !((row_nxt >= V_SYNC_START) && (row_nxt < V_SYNC_END));

	////////////////////////////////////////////////////////////
	// Counters and registered levels
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase     <= PH_ACTIVE;
			col       <= '0;
			row       <= '0;
			// Blanked with sync idle until counting starts
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_active  <= 1'b0;
		end else begin
			phase     <= phase_nxt;
			col       <= col_nxt;
			row       <= row_nxt;
			o_hblank  <= hblank_nxt;
			o_vblank  <= vblank_nxt;
			o_hsync_n <= hsync_n_nxt;
			o_vsync_n <= vsync_n_nxt;
			o_active  <= !(hblank_nxt || vblank_nxt);
		end
	end

	// Coordinates line up with the registered levels
	assign o_col = col;
	assign o_row = row;

endmodule

/* hdl/clut_index_decode.sv */
`timescale 1ns/1ns

module clut_index_decode (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic [video_pkg::DOT_W-1:0] i_dot,
	input  logic                        i_bank,
	input  logic                        i_hsync_n,
	input  logic                        i_vsync_n,
	input  logic                        i_hblank,
	input  logic                        i_vblank,
	output logic [video_pkg::DOT_W-1:0] o_index,
	output logic                        o_hsync_n,
	output logic                        o_vsync_n,
	output logic                        o_hblank,
	output logic                        o_vblank
);

	import video_pkg::*;

	// One entry per bank and dot pair
	localparam int TABLE_DEPTH = 2 ** (DOT_W + 1);

	logic [DOT_W-1:0] index_table [TABLE_DEPTH];
	logic [DOT_W:0]   table_addr;

	// Bank selects the upper half of the palette
	// Dot zero stays transparent in either bank
	function automatic logic [DOT_W-1:0] clut_entry(input int addr);
		logic [DOT_W-1:0] dot;
		logic             bank;
		dot  = addr[DOT_W-1:0];
		bank = addr[DOT_W];
		if (dot == '0) begin
			return '0;
		end
		return dot + {bank, {(DOT_W - 1){1'b0}}};
	endfunction

	// Table fixed at elaboration, acts as a ROM
	for (genvar g = 0; g < TABLE_DEPTH; g++) begin : g_index_table
		assign index_table[g] = clut_entry(g);
	end

	assign table_addr = {i_bank, i_dot};

	// Registered lookup
	always_ff @(posedge i_clk) begin
		o_index <= index_table[table_addr];
	end

	// Timing levels follow the index by one cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
		end else begin
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
			o_hblank  <= i_hblank;
			o_vblank  <= i_vblank;
		end
	end

endmodule

/* hdl/palette_lookup.sv */
`timescale 1ns/1ns

module palette_lookup (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [video_pkg::DOT_W-1:0]   i_index,
	input  logic                          i_hsync_n,
	input  logic                          i_vsync_n,
	input  logic                          i_hblank,
	input  logic                          i_vblank,
	output logic [video_pkg::COLOR_W-1:0] o_red,
	output logic [video_pkg::COLOR_W-1:0] o_green,
	output logic [video_pkg::COLOR_W-1:0] o_blue,
	output logic                          o_hsync_n,
	output logic                          o_vsync_n,
	output logic                          o_hblank,
	output logic                          o_vblank
);

	import video_pkg::*;

	localparam int PAL_DEPTH = 2 ** DOT_W;

	// Packed as red, green, blue
	logic [3*COLOR_W-1:0] palette_table [PAL_DEPTH];

	// Red from low nibble, green from high nibble
	// Blue mixes both
	function automatic logic [3*COLOR_W-1:0] palette_entry(input int idx);
		logic [COLOR_W-1:0] lo;
		logic [COLOR_W-1:0] hi;
		lo = idx[COLOR_W-1:0];
		hi = idx[2*COLOR_W-1:COLOR_W];
		return {lo, hi, lo ^ hi};
	endfunction

	for (genvar g = 0; g < PAL_DEPTH; g++) begin : g_palette_table
		assign palette_table[g] = palette_entry(g);
	end

	// Synchronous read straight into the colour registers
	always_ff @(posedge i_clk) begin
		{o_red, o_green, o_blue} <= palette_table[i_index];
	end

	// Sync and blank carried alongside
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
		end else begin
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
			o_hblank  <= i_hblank;
			o_vblank  <= i_vblank;
		end
	end

endmodule

/* hdl/video_output.sv */
`timescale 1ns/1ns

module video_output (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [video_pkg::COLOR_W-1:0] i_red,
	input  logic [video_pkg::COLOR_W-1:0] i_green,
	input  logic [video_pkg::COLOR_W-1:0] i_blue,
	input  logic                          i_hsync_n,
	input  logic                          i_vsync_n,
	input  logic                          i_hblank,
	input  logic                          i_vblank,
	output logic [video_pkg::COLOR_W-1:0] o_red,
	output logic [video_pkg::COLOR_W-1:0] o_green,
	output logic [video_pkg::COLOR_W-1:0] o_blue,
	output logic                          o_hsync_n,
	output logic                          o_vsync_n,
	output logic                          o_csync_n,
	output logic                          o_hblank,
	output logic                          o_vblank
);

	import video_pkg::*;

	logic blanking;

	// Either blank forces black
	assign blanking = i_hblank || i_vblank;

	////////////////////////////////////////////////////////////
	// Final output flops
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_red     <= '0;
			o_green   <= '0;
			o_blue    <= '0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
			o_csync_n <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
		end else begin
			o_red     <= blanking ? {COLOR_W{1'b0}} : i_red;
			o_green   <= blanking ? {COLOR_W{1'b0}} : i_green;
			o_blue    <= blanking ? {COLOR_W{1'b0}} : i_blue;
			o_hsync_n <= i_hsync_n;
			o_vsync_n <= i_vsync_n;
			// Composite low while either sync is low
			o_csync_n <= i_hsync_n && i_vsync_n;
			o_hblank  <= i_hblank;
			o_vblank  <= i_vblank;
		end
	end

endmodule

/* hdl/videogen_top.sv */
`timescale 1ns/1ns

module videogen_top #(
	parameter int ACTIVE_COLS = video_pkg::DEF_ACTIVE_COLS,
	parameter int FRONT_H     = video_pkg::DEF_FRONT_H,
	parameter int SYNC_H      = video_pkg::DEF_SYNC_H,
	parameter int BACK_H      = video_pkg::DEF_BACK_H,
	parameter int ACTIVE_ROWS = video_pkg::DEF_ACTIVE_ROWS,
	parameter int FRONT_V     = video_pkg::DEF_FRONT_V,
	parameter int SYNC_V      = video_pkg::DEF_SYNC_V,
	parameter int BACK_V      = video_pkg::DEF_BACK_V
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [video_pkg::DOT_W-1:0]   i_dot,
	input  logic                          i_bank,
	output logic [video_pkg::COUNT_W-1:0] o_col,
	output logic [video_pkg::COUNT_W-1:0] o_row,
	output logic                          o_active,
	output logic [video_pkg::COLOR_W-1:0] o_red,
	output logic [video_pkg::COLOR_W-1:0] o_green,
	output logic [video_pkg::COLOR_W-1:0] o_blue,
	output logic                          o_hsync_n,
	output logic                          o_vsync_n,
	output logic                          o_csync_n,
	output logic                          o_hblank,
	output logic                          o_vblank
);

	import video_pkg::*;

	// Timing block levels, aligned with o_col and o_row
	logic t_hsync_n, t_vsync_n, t_hblank, t_vblank;
	// Decode stage outputs
	logic [DOT_W-1:0] d_index;
	logic d_hsync_n, d_vsync_n, d_hblank, d_vblank;
	// Execute stage outputs
	logic [COLOR_W-1:0] p_red, p_green, p_blue;
	logic p_hsync_n, p_vsync_n, p_hblank, p_vblank;

	video_timing #(
		.ACTIVE_COLS(ACTIVE_COLS), .FRONT_H(FRONT_H), .SYNC_H(SYNC_H), .BACK_H(BACK_H),
		.ACTIVE_ROWS(ACTIVE_ROWS), .FRONT_V(FRONT_V), .SYNC_V(SYNC_V), .BACK_V(BACK_V)
	) u_timing (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .o_col(o_col), .o_row(o_row), .o_active(o_active),
		.o_hsync_n(t_hsync_n), .o_vsync_n(t_vsync_n), .o_hblank(t_hblank), .o_vblank(t_vblank)
	);

	// Stage 1, bank and dot to palette index
	clut_index_decode u_decode (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_dot(i_dot), .i_bank(i_bank),
		.i_hsync_n(t_hsync_n), .i_vsync_n(t_vsync_n), .i_hblank(t_hblank), .i_vblank(t_vblank),
		.o_index(d_index),
		.o_hsync_n(d_hsync_n), .o_vsync_n(d_vsync_n), .o_hblank(d_hblank), .o_vblank(d_vblank)
	);

	// Stage 2, index to RGB
	palette_lookup u_palette (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_index(d_index),
		.i_hsync_n(d_hsync_n), .i_vsync_n(d_vsync_n), .i_hblank(d_hblank), .i_vblank(d_vblank),
		.o_red(p_red), .o_green(p_green), .o_blue(p_blue),
		.o_hsync_n(p_hsync_n), .o_vsync_n(p_vsync_n), .o_hblank(p_hblank), .o_vblank(p_vblank)
	);

	// Stage 3, blanking and composite sync
	video_output u_output (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_red(p_red), .i_green(p_green), .i_blue(p_blue),
		.i_hsync_n(p_hsync_n), .i_vsync_n(p_vsync_n), .i_hblank(p_hblank), .i_vblank(p_vblank),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue),
		.o_hsync_n(o_hsync_n), .o_vsync_n(o_vsync_n), .o_csync_n(o_csync_n),
		.o_hblank(o_hblank), .o_vblank(o_vblank)
	);

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD_NS = 8
) (
	output logic o_clk
);

	// Starts low, first rising edge at half a period
	initial begin
		o_clk = 1'b0;
	end

	// Free running, symmetric duty cycle
	always begin
		#(PERIOD_NS / 2);
		o_clk = ~o_clk;
	end

endmodule

/* dv/videogen_tb.sv */
`timescale 1ns/1ns

module videogen_tb;

	import video_pkg::*;

	////////////////////////////////////////////////////////////
	// Small raster for simulation
	////////////////////////////////////////////////////////////

	localparam int H_ACTIVE     = 16;
	localparam int H_FRONT      = 2;
	localparam int H_SYNC       = 3;
	localparam int H_BACK       = 3;
	localparam int V_ACTIVE     = 6;
	localparam int V_FRONT      = 1;
	localparam int V_SYNC       = 2;
	localparam int V_BACK       = 1;
	localparam int LINE_CLKS    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_LINES  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CLKS   = LINE_CLKS * FRAME_LINES;
	localparam int RESET_CYCLES = 16;
	// Two whole frames plus pipeline flush
	localparam int RUN_CYCLES   = 2 * FRAME_CLKS + 8;
	localparam int TIMEOUT      = 3 * FRAME_CLKS + RESET_CYCLES + 100;
	localparam logic [31:0] SEED = 32'h80cd_e960;

	// Test numbers
	localparam int T_RESET  = 1;
	localparam int T_COLOUR = 2;
	localparam int T_BLANK  = 3;
	localparam int T_HTIME  = 4;
	localparam int T_VSYNC  = 5;

	// One expected output slot
	typedef struct packed {
		logic                 hsync_n;
		logic                 vsync_n;
		logic                 hblank;
		logic                 vblank;
		logic                 transparent;
		logic [3*COLOR_W-1:0] rgb;
	} slot_t;

	localparam slot_t RESET_SLOT = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, '0};

	logic               clk;
	logic               rst_n;
	logic [DOT_W-1:0]   dot = '0;
	logic               bank = 1'b0;
	logic [COUNT_W-1:0] col;
	logic [COUNT_W-1:0] row;
	logic               active;
	logic [COLOR_W-1:0] red, green, blue;
	logic               hsync_n, vsync_n, csync_n, hblank, vblank;

	// Reference model state
	slot_t exp_q [$];
	int    m_col = 0;
	int    m_row = 0;
	logic  m_running = 1'b0;
	int    lines_done = 0;
	int    slot = 0;
	int    cycle_count = 0;
	// Edge tracking on the outputs
	logic  prev_hsync_n = 1'b1;
	logic  prev_vsync_n = 1'b1;
	logic  prev_active = 1'b0;
	int    prev_col = 0;
	int    hs_fall_slot = -1;
	int    vs_fall_slot = -1;
	int    transparent_seen = 0;
	// Per test bookkeeping
	int    n_checks [1:5] = '{0, 0, 0, 0, 0};
	int    n_errors [1:5] = '{0, 0, 0, 0, 0};
	int    tests_failed = 0;

	clock_gen #(.PERIOD_NS(8)) clk_gen0 (.o_clk(clk));

	videogen_top #(
		.ACTIVE_COLS(H_ACTIVE), .FRONT_H(H_FRONT), .SYNC_H(H_SYNC), .BACK_H(H_BACK),
		.ACTIVE_ROWS(V_ACTIVE), .FRONT_V(V_FRONT), .SYNC_V(V_SYNC), .BACK_V(V_BACK)
	) dut0 (
		.i_clk(clk), .i_rst_n(rst_n), .i_dot(dot), .i_bank(bank),
		.o_col(col), .o_row(row), .o_active(active),
		.o_red(red), .o_green(green), .o_blue(blue),
		.o_hsync_n(hsync_n), .o_vsync_n(vsync_n), .o_csync_n(csync_n),
		.o_hblank(hblank), .o_vblank(vblank)
	);

	////////////////////////////////////////////////////////////
	// Colour rules
	////////////////////////////////////////////////////////////

	// Bank adds 128, dot zero is transparent
	function automatic logic [DOT_W-1:0] clut_index(input logic [DOT_W-1:0] d, input logic b);
		int v;
		if (d == '0) begin
			return '0;
		end
		v = (int'(d) + (b ? 128 : 0)) % 256;
		return DOT_W'(v);
	endfunction

	// Red low nibble, green high nibble, blue their XOR
	function automatic logic [3*COLOR_W-1:0] palette_rgb(input logic [DOT_W-1:0] idx);
		logic [3:0] r;
		logic [3:0] g;
		r = idx[3:0];
		g = idx[7:4];
		return {r, g, r ^ g};
	endfunction

	task automatic check_value(input int id, input logic [31:0] got, input logic [31:0] want,
			input string what);
		n_checks[id]++;
		if (got !== want) begin
			n_errors[id]++;
			$display("ERROR at %0t ns: test %0d, %s is %0h, expected %0h",
				$time, id, what, got, want);
		end
	endtask

	task automatic report_test(input int id, input string name);
		if (n_checks[id] == 0) begin
			$display("Test %0d (%s) ran without making a single check", id, name);
		end
		if (n_errors[id] == 0 && n_checks[id] > 0) begin
			$display("Test %0d %s: ok, %0d checks", id, name, n_checks[id]);
		end else begin
			$display("Test %0d %s: failed, %0d checks, %0d errors",
				id, name, n_checks[id], n_errors[id]);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// New random pixel every clock, dot zero about one in eight
	always @(posedge clk) begin
		if ($urandom_range(7) == 0) begin
			dot <= '0;
		end else begin
			dot <= DOT_W'($urandom);
		end
		bank <= 1'($urandom);
	end

	// Cycle limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT) begin
			$display("Run timed out after %0d cycles without finishing", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Model and checks, sampled mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin : model_and_check
		slot_t cur;
		slot_t old;
		logic  exp_active;
		cur = RESET_SLOT;
		// First slot out of reset still shows the reset levels
		if (rst_n && m_running) begin
			cur.hblank  = (m_col >= H_ACTIVE);
			cur.hsync_n = !(m_col >= H_ACTIVE + H_FRONT && m_col < H_ACTIVE + H_FRONT + H_SYNC);
			cur.vblank  = (m_row >= V_ACTIVE);
			cur.vsync_n = !(m_row >= V_ACTIVE + V_FRONT && m_row < V_ACTIVE + V_FRONT + V_SYNC);
		end
		// Only in the upper bank does dot zero differ from plain index arithmetic
		cur.transparent = (dot == '0) && bank;
		if (!(cur.hblank || cur.vblank)) begin
			cur.rgb = palette_rgb(clut_index(dot, bank));
		end
		exp_active = !(cur.hblank || cur.vblank);
		exp_q.push_back(cur);
		// Entry from three slots back meets the outputs now
		old = exp_q.pop_front();

		if (!rst_n) begin
			check_value(T_RESET, 32'({hsync_n, vsync_n, csync_n}), 32'h7, "sync outputs");
			check_value(T_RESET, 32'({hblank, vblank}), 32'h3, "blank outputs");
			check_value(T_RESET, 32'({red, green, blue}), 32'h0, "colour");
			check_value(T_RESET, 32'(active), 32'h0, "o_active");
		end else begin
			check_value(T_HTIME, 32'(col), 32'(m_col), "o_col");
			check_value(T_HTIME, 32'(active), 32'(exp_active), "o_active");
			check_value(T_VSYNC, 32'(row), 32'(m_row), "o_row");
			check_value(T_BLANK, 32'(hblank), 32'(old.hblank), "o_hblank");
			check_value(T_BLANK, 32'(vblank), 32'(old.vblank), "o_vblank");
			if (hblank || vblank) begin
				check_value(T_BLANK, 32'({red, green, blue}), 32'h0, "colour under blank");
			end
			if (!(old.hblank || old.vblank)) begin
				check_value(T_COLOUR, 32'({red, green, blue}), 32'(old.rgb), "pixel colour");
				if (old.transparent) begin
					transparent_seen++;
				end
			end
			check_value(T_HTIME, 32'(hsync_n), 32'(old.hsync_n), "o_hsync_n");
			check_value(T_VSYNC, 32'(vsync_n), 32'(old.vsync_n), "o_vsync_n");
			check_value(T_VSYNC, 32'(csync_n), 32'(old.hsync_n && old.vsync_n), "o_csync_n");

			// Sync period and width
			if (prev_hsync_n && !hsync_n) begin
				if (hs_fall_slot >= 0) begin
					check_value(T_HTIME, 32'(slot - hs_fall_slot), LINE_CLKS, "hsync period");
				end
				hs_fall_slot = slot;
			end
			if (!prev_hsync_n && hsync_n) begin
				check_value(T_HTIME, 32'(slot - hs_fall_slot), H_SYNC, "hsync width");
			end
			if (prev_vsync_n && !vsync_n) begin
				if (vs_fall_slot >= 0) begin
					check_value(T_VSYNC, 32'(slot - vs_fall_slot), FRAME_CLKS, "vsync period");
				end
				vs_fall_slot = slot;
			end
			if (!prev_vsync_n && vsync_n) begin
				check_value(T_VSYNC, 32'(slot - vs_fall_slot), V_SYNC * LINE_CLKS, "vsync width");
			end

			// Active run spans columns 0 to 15, line 0 starts late
			if (active && !prev_active && lines_done > 0) begin
				check_value(T_HTIME, 32'(col), 32'h0, "first active column");
			end
			if (active && prev_active) begin
				check_value(T_HTIME, 32'(col), 32'(prev_col + 1), "next active column");
			end
			if (!active && prev_active) begin
				check_value(T_HTIME, 32'(prev_col), H_ACTIVE - 1, "last active column");
			end
		end

		prev_hsync_n = hsync_n;
		prev_vsync_n = vsync_n;
		prev_active  = active;
		prev_col     = int'(col);

		// Step the counter model
		if (rst_n) begin
			m_running = 1'b1;
			if (m_col == LINE_CLKS - 1) begin
				m_col = 0;
				lines_done++;
				m_row = (m_row == FRAME_LINES - 1) ? 0 : m_row + 1;
			end else begin
				m_col++;
			end
		end
		slot++;
	end

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		int total_checks;
		int total_errors;
		void'($urandom(SEED));
		rst_n = 1'b0;
		// Pipeline holds reset levels at start
		repeat (3) exp_q.push_back(RESET_SLOT);
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		report_test(T_RESET, "reset state");

		repeat (RUN_CYCLES) @(posedge clk);
		$display("Transparent pixels checked: %0d", transparent_seen);
		if (transparent_seen == 0) begin
			n_errors[T_COLOUR]++;
			$display("Test %0d never showed dot zero from the upper bank on an active pixel",
				T_COLOUR);
		end
		report_test(T_COLOUR, "pixel colour");
		report_test(T_BLANK, "blanking");
		report_test(T_HTIME, "horizontal timing");
		report_test(T_VSYNC, "vertical and composite sync");

		total_checks = 0;
		total_errors = 0;
		for (int i = 1; i <= 5; i++) begin
			total_checks += n_checks[i];
			total_errors += n_errors[i];
		end
		$display("Summary: 5 tests, %0d passed, %0d failed, %0d checks, %0d errors",
			5 - tests_failed, tests_failed, total_checks, total_errors);
		if (tests_failed == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/clut_index_decode.sv
hdl/palette_lookup.sv
hdl/video_output.sv
hdl/videogen_top.sv
dv/clock_gen.sv
dv/videogen_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= videogen_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
